// ==== include/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Clock cycles per 16x sample strobe.
// With 16 samples per bit, one bit lasts 64 cycles.
`define UART_CLK_DIV 4

// Depth of the serial input synchronizer.
`define UART_SYNC_STAGES 2

// Sample strobes per bit time.
`define UART_SAMPLES_PER_BIT 16

`endif

// ==== source/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

    // Number of data bits in a frame.
    typedef enum logic [1:0] {
        DBIT5,
        DBIT6,
        DBIT7,
        DBIT8
    } uart_data_length_t;

    // Stop bits after the data or parity bit.
    typedef enum logic {
        STOP1,
        STOP2
    } uart_stop_bits_t;

    // Encoded value is the start value of the parity accumulator.
    typedef enum logic {
        EVEN = 1'b0,
        ODD  = 1'b1
    } uart_parity_mode_t;

endpackage : uart_cfg_pkg

// ==== source/uart_rx_pkg.sv ====
package uart_rx_pkg;

    // Received word, right-aligned.
    typedef logic [7:0] rx_byte_t;

    // Status of a delivered word.
    typedef logic [1:0] rx_status_t;

    // Bit positions inside rx_status_t.
    localparam int RX_STATUS_PERR = 0;
    localparam int RX_STATUS_OVRN = 1;

endpackage : uart_rx_pkg

// ==== source/uart_baud_gen.sv ====
`timescale 1ns/1ns
`include "uart_params.svh"

module uart_baud_gen #(
    parameter int DIV = `UART_CLK_DIV
) (
    input  logic clk_i,
    input  logic rst_n_i,
    output logic sample_tick_o
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            div_cnt       <= '0;
            sample_tick_o <= 1'b0;
        end else begin
            // One strobe per full count.
            sample_tick_o <= (div_cnt == CNT_LAST);
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule : uart_baud_gen

// ==== source/uart_rx_sync.sv ====
`timescale 1ns/1ns
`include "uart_params.svh"

module uart_rx_sync #(
    parameter int STAGES = `UART_SYNC_STAGES
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic rx_async_i,
    output logic rx_sync_o
);

    logic [STAGES-1:0] sync_chain;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Line idles high.
            sync_chain <= '1;
        end else begin
            sync_chain <= {sync_chain[STAGES-2:0], rx_async_i};
        end
    end

    assign rx_sync_o = sync_chain[STAGES-1];

endmodule : uart_rx_sync

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ns
`include "uart_params.svh"

module uart_receiver (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            sample_i,
    input  logic                            uart_rx_i,
    input  uart_cfg_pkg::uart_data_length_t data_length_i,
    input  uart_cfg_pkg::uart_stop_bits_t   stop_bits_i,
    input  uart_cfg_pkg::uart_parity_mode_t parity_mode_i,
    input  logic                            parity_enable_i,
    output uart_rx_pkg::rx_byte_t           rx_data_o,
    output logic                            rx_done_o,
    output logic                            rx_idle_o,
    output logic                            parity_error_o
);

    localparam logic [3:0] LAST_SAMPLE = 4'(`UART_SAMPLES_PER_BIT - 1);
    localparam logic [3:0] MID_SAMPLE  = 4'(`UART_SAMPLES_PER_BIT / 2 - 1);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

    rx_state_t             state_crt;
    rx_state_t             state_nxt;
    logic [3:0]            sample_cnt;
    logic [2:0]            bit_cnt;
    logic [2:0]            last_bit;
    logic                  stop_second;
    uart_rx_pkg::rx_byte_t shift_reg;
    logic                  parity_acc;
    logic                  parity_err;
    logic                  bit_end;
    logic                  frame_start;
    logic                  cnt_clear;
    logic                  shift_data;
    logic                  check_parity;
    logic                  stop_wait;

    // Counting from mid-start, the last sample lands at mid-bit.
    assign bit_end  = sample_i && (sample_cnt == LAST_SAMPLE);
    assign last_bit = {1'b0, data_length_i} + 3'd4;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_crt   <= IDLE;
            sample_cnt  <= '0;
            bit_cnt     <= '0;
            stop_second <= 1'b0;
        end else begin
            state_crt <= state_nxt;
            if (cnt_clear) begin
                sample_cnt <= '0;
            end else if (sample_i && (state_crt != IDLE)) begin
                sample_cnt <= sample_cnt + 4'd1;
            end
            if (frame_start) begin
                bit_cnt     <= '0;
                stop_second <= 1'b0;
            end else begin
                if (shift_data) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                if (stop_wait) begin
                    stop_second <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_start) begin
            shift_reg  <= '0;
            parity_acc <= parity_mode_i;
            parity_err <= 1'b0;
        end else begin
            // LSB arrives first, so shift in from the top.
            if (shift_data) begin
                shift_reg  <= {uart_rx_i, shift_reg[7:1]};
                parity_acc <= parity_acc ^ uart_rx_i;
            end
            if (check_parity) begin
                parity_err <= (parity_acc != uart_rx_i);
            end
        end
    end

    // Short words sit in the upper bits of the shift register.
    always_comb begin
        case (data_length_i)
            uart_cfg_pkg::DBIT5: rx_data_o = shift_reg >> 3;
            uart_cfg_pkg::DBIT6: rx_data_o = shift_reg >> 2;
            uart_cfg_pkg::DBIT7: rx_data_o = shift_reg >> 1;
            default:             rx_data_o = shift_reg;
        endcase
    end

    always_comb begin
        state_nxt      = state_crt;
        rx_idle_o      = 1'b0;
        rx_done_o      = 1'b0;
        parity_error_o = 1'b0;
        frame_start    = 1'b0;
        cnt_clear      = 1'b0;
        shift_data     = 1'b0;
        check_parity   = 1'b0;
        stop_wait      = 1'b0;

        case (state_crt)
            IDLE: begin
                rx_idle_o = 1'b1;
                if (!uart_rx_i) begin
                    state_nxt = START;
                    cnt_clear = 1'b1;
                end
            end
            START: begin
                // Glitch on the line, not a real start bit.
                if (uart_rx_i) begin
                    state_nxt = IDLE;
                end else if (sample_i && (sample_cnt == MID_SAMPLE)) begin
                    state_nxt   = DATA;
                    cnt_clear   = 1'b1;
                    frame_start = 1'b1;
                end
            end
            DATA: begin
                if (bit_end) begin
                    shift_data = 1'b1;
                    cnt_clear  = 1'b1;
                    if (bit_cnt == last_bit) begin
                        state_nxt = parity_enable_i ? PARITY : STOP;
                    end
                end
            end
            PARITY: begin
                if (bit_end) begin
                    state_nxt    = STOP;
                    check_parity = 1'b1;
                    cnt_clear    = 1'b1;
                end
            end
            STOP: begin
                if (bit_end) begin
                    cnt_clear = 1'b1;
                    if ((stop_bits_i == uart_cfg_pkg::STOP1) || stop_second) begin
                        state_nxt      = IDLE;
                        rx_done_o      = 1'b1;
                        parity_error_o = parity_err;
                    end else begin
                        stop_wait = 1'b1;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

endmodule : uart_receiver

// ==== source/uart_rx_handoff.sv ====
`timescale 1ns/1ns

module uart_rx_handoff (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  uart_rx_pkg::rx_byte_t   rx_data_i,
    input  logic                    rx_done_i,
    input  logic                    parity_error_i,
    input  logic                    ack_i,
    output logic                    req_o,
    output uart_rx_pkg::rx_byte_t   data_o,
    output uart_rx_pkg::rx_status_t status_o
);

    typedef enum logic [1:0] {READY, OFFER, RELEASE} handoff_state_t;

    handoff_state_t state;
    logic           overrun;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= READY;
            overrun  <= 1'b0;
            data_o   <= '0;
            status_o <= '0;
        end else begin
            case (state)
                READY: begin
                    if (rx_done_i) begin
                        data_o   <= rx_data_i;
                        status_o <= '0;
                        status_o[uart_rx_pkg::RX_STATUS_PERR] <= parity_error_i;
                        status_o[uart_rx_pkg::RX_STATUS_OVRN] <= overrun;
                        overrun  <= 1'b0;
                        state    <= OFFER;
                    end
                end
                OFFER: begin
                    if (ack_i) begin
                        state <= RELEASE;
                    end
                end
                default: begin
                    // Wait for the system to drop ack.
                    if (!ack_i) begin
                        state <= READY;
                    end
                end
            endcase
            // Word pending, this frame is dropped.
            if (rx_done_i && (state != READY)) begin
                overrun <= 1'b1;
            end
        end
    end

    assign req_o = (state == OFFER);

endmodule : uart_rx_handoff

// ==== source/uart_rx_top.sv ====
`timescale 1ns/1ns

module uart_rx_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            uart_rx_i,
    input  uart_cfg_pkg::uart_data_length_t data_length_i,
    input  uart_cfg_pkg::uart_stop_bits_t   stop_bits_i,
    input  uart_cfg_pkg::uart_parity_mode_t parity_mode_i,
    input  logic                            parity_enable_i,
    input  logic                            ack_i,
    output logic                            req_o,
    output uart_rx_pkg::rx_byte_t           data_o,
    output uart_rx_pkg::rx_status_t         status_o,
    output logic                            rx_idle_o
);

    logic                  rx_line;
    logic                  sample_tick;
    uart_rx_pkg::rx_byte_t rx_data;
    logic                  rx_done;
    logic                  parity_error;

    uart_rx_sync u_sync (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rx_async_i (uart_rx_i),
        .rx_sync_o  (rx_line)
    );

    uart_baud_gen u_baud (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .sample_tick_o (sample_tick)
    );

    uart_receiver u_receiver (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .sample_i        (sample_tick),
        .uart_rx_i       (rx_line),
        .data_length_i   (data_length_i),
        .stop_bits_i     (stop_bits_i),
        .parity_mode_i   (parity_mode_i),
        .parity_enable_i (parity_enable_i),
        .rx_data_o       (rx_data),
        .rx_done_o       (rx_done),
        .rx_idle_o       (rx_idle_o),
        .parity_error_o  (parity_error)
    );

    uart_rx_handoff u_handoff (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rx_data_i      (rx_data),
        .rx_done_i      (rx_done),
        .parity_error_i (parity_error),
        .ack_i          (ack_i),
        .req_o          (req_o),
        .data_o         (data_o),
        .status_o       (status_o)
    );

endmodule : uart_rx_top

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release away from the sampling edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

// ==== verification/uart_rx_checker.sv ====
`timescale 1ns/1ns

module uart_rx_checker (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    ack_i,
    input logic                    req_i,
    input uart_rx_pkg::rx_byte_t   data_i,
    input uart_rx_pkg::rx_status_t status_i
);

    int unsigned fail_count = 0;

    // No word offered straight out of reset.
    req_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !req_i)
        else begin
            fail_count++;
            $error("req_o high in the cycle after reset");
        end

    // An offer is only withdrawn after ack.
    req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i && !ack_i |=> req_i)
        else begin
            fail_count++;
            $error("req_o dropped before ack_i");
        end

    offer_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |=> !req_i || ($stable(data_i) && $stable(status_i)))
        else begin
            fail_count++;
            $error("data_o or status_o changed during an offer");
        end

    // New offer waits for the previous ack to go low.
    no_rise_during_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) |-> !ack_i)
        else begin
            fail_count++;
            $error("req_o rose while ack_i was high");
        end

endmodule : uart_rx_checker

bind uart_rx_top uart_rx_checker chk0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ack_i    (ack_i),
    .req_i    (req_o),
    .data_i   (data_o),
    .status_i (status_o)
);

// ==== verification/uart_rx_tb.sv ====
`timescale 1ns/1ns
`include "uart_params.svh"

module uart_rx_tb;

    localparam int BIT_CYCLES   = `UART_CLK_DIV * `UART_SAMPLES_PER_BIT;
    localparam int FRAME_CYCLES = 12 * BIT_CYCLES;

    logic                            clk;
    logic                            rst_n;
    logic                            uart_rx;
    logic                            ack;
    uart_cfg_pkg::uart_data_length_t data_length;
    uart_cfg_pkg::uart_stop_bits_t   stop_bits;
    uart_cfg_pkg::uart_parity_mode_t parity_mode;
    logic                            parity_enable;
    logic                            req;
    uart_rx_pkg::rx_byte_t           data;
    uart_rx_pkg::rx_status_t         status;
    logic                            rx_idle;
    logic [31:0]                     rng;
    int                              errors;
    int                              timeouts;

    tb_clock_gen clk_gen0 (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    uart_rx_top dut0 (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .uart_rx_i       (uart_rx),
        .data_length_i   (data_length),
        .stop_bits_i     (stop_bits),
        .parity_mode_i   (parity_mode),
        .parity_enable_i (parity_enable),
        .ack_i           (ack),
        .req_o           (req),
        .data_o          (data),
        .status_o        (status),
        .rx_idle_o       (rx_idle)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] next_word();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    // Word length 5 to 8, right-aligned.
    function automatic logic [7:0] length_mask(input uart_cfg_pkg::uart_data_length_t len);
        return 8'hFF >> (3 - int'(len));
    endfunction

    task automatic report_mismatch(input string what, input logic [7:0] got,
                                   input logic [7:0] exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic set_format(input uart_cfg_pkg::uart_data_length_t len,
                              input uart_cfg_pkg::uart_stop_bits_t stop,
                              input logic pen,
                              input uart_cfg_pkg::uart_parity_mode_t pmode);
        data_length   = len;
        stop_bits     = stop;
        parity_enable = pen;
        parity_mode   = pmode;
    endtask

    task automatic drive_bit(input logic value);
        uart_rx = value;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] payload, input logic flip_parity);
        int   nbits;
        logic par;
        nbits = int'(data_length) + 5;
        // Even parity makes the count of ones even, odd makes it odd.
        par = ^(payload & length_mask(data_length));
        if (parity_mode == uart_cfg_pkg::ODD) begin
            par = ~par;
        end
        par = par ^ flip_parity;
        drive_bit(1'b0);
        // Receiver has left idle by the end of the start bit.
        assert (!rx_idle) else report_mismatch("rx_idle_o", {7'b0, rx_idle}, 8'h00);
        for (int i = 0; i < nbits; i++) begin
            drive_bit(payload[i]);
        end
        if (parity_enable) begin
            drive_bit(par);
        end
        drive_bit(1'b1);
        if (stop_bits == uart_cfg_pkg::STOP2) begin
            drive_bit(1'b1);
        end
    endtask

    task automatic wait_req(input logic level, input int limit);
        int n;
        n = 0;
        while ((req !== level) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (req !== level) begin
            timeouts++;
            $display("Timeout at %0t ns: req_o did not go to %b within %0d cycles",
                     $time, level, limit);
        end
    endtask

    task automatic take_word(input logic [7:0] exp_data, input logic [1:0] exp_status);
        wait_req(1'b1, FRAME_CYCLES);
        assert (data == exp_data) else report_mismatch("data_o", data, exp_data);
        assert (status == exp_status)
            else report_mismatch("status_o", {6'b0, status}, {6'b0, exp_status});
        ack = 1'b1;
        wait_req(1'b0, 16);
        ack = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_no_word(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!req) else report_mismatch("req_o", {7'b0, req}, 8'h00);
        end
    endtask

    task automatic run_pair(input uart_cfg_pkg::uart_data_length_t len,
                            input uart_cfg_pkg::uart_stop_bits_t stop);
        logic [7:0] first;
        logic [7:0] second;
        set_format(len, stop, 1'b0, uart_cfg_pkg::EVEN);
        first  = next_word();
        second = next_word();
        send_frame(first, 1'b0);
        // Second start bit follows the first stop bit directly.
        fork
            send_frame(second, 1'b0);
            take_word(first & length_mask(len), 2'b00);
        join
        take_word(second & length_mask(len), 2'b00);
    endtask

    initial begin
        logic [7:0] w1;
        logic [7:0] w3;
        logic [7:0] w4;
        uart_rx  = 1'b1;
        ack      = 1'b0;
        rng      = 32'd40;
        errors   = 0;
        timeouts = 0;
        set_format(uart_cfg_pkg::DBIT8, uart_cfg_pkg::STOP1, 1'b0, uart_cfg_pkg::EVEN);
        repeat (3) @(negedge clk);

        assert (!req) else report_mismatch("req_o", {7'b0, req}, 8'h00);
        assert (rx_idle) else report_mismatch("rx_idle_o", {7'b0, rx_idle}, 8'h01);
        check_no_word(2 * FRAME_CYCLES);

        // 8N1 random bytes.
        for (int i = 0; i < 8; i++) begin
            w1 = next_word();
            send_frame(w1, 1'b0);
            take_word(w1, 2'b00);
        end

        run_pair(uart_cfg_pkg::DBIT5, uart_cfg_pkg::STOP1);
        run_pair(uart_cfg_pkg::DBIT6, uart_cfg_pkg::STOP2);
        run_pair(uart_cfg_pkg::DBIT7, uart_cfg_pkg::STOP1);
        run_pair(uart_cfg_pkg::DBIT5, uart_cfg_pkg::STOP2);

        // Good and flipped parity bits in both modes.
        for (int f = 0; f < 4; f++) begin
            set_format(uart_cfg_pkg::DBIT8, uart_cfg_pkg::STOP1, 1'b1,
                       (f < 2) ? uart_cfg_pkg::EVEN : uart_cfg_pkg::ODD);
            w1 = next_word();
            send_frame(w1, f[0]);
            take_word(w1, {1'b0, f[0]});
        end

        // Low glitch shorter than half a bit.
        set_format(uart_cfg_pkg::DBIT8, uart_cfg_pkg::STOP1, 1'b0, uart_cfg_pkg::EVEN);
        uart_rx = 1'b0;
        repeat (BIT_CYCLES / 2 - 8) @(negedge clk);
        uart_rx = 1'b1;
        check_no_word(2 * FRAME_CYCLES);
        w1 = next_word();
        send_frame(w1, 1'b0);
        take_word(w1, 2'b00);

        // Second frame arrives while the first is still offered.
        w1 = next_word();
        send_frame(w1, 1'b0);
        send_frame(next_word(), 1'b0);
        take_word(w1, 2'b00);
        w3 = next_word();
        send_frame(w3, 1'b0);
        take_word(w3, 2'b10);
        w4 = next_word();
        send_frame(w4, 1'b0);
        take_word(w4, 2'b00);

        $display("Result: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut0.chk0.fail_count);
        if ((errors == 0) && (timeouts == 0) && (dut0.chk0.fail_count == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : uart_rx_tb

// ==== compile.f ====
+incdir+include
source/uart_cfg_pkg.sv
source/uart_rx_pkg.sv
source/uart_baud_gen.sv
source/uart_rx_sync.sv
source/uart_receiver.sv
source/uart_rx_handoff.sv
source/uart_rx_top.sv
verification/tb_clock_gen.sv
verification/uart_rx_checker.sv
verification/uart_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART receiver testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module uart_rx_tb \
    -o uart_rx_sim

# Let the testbench reach its own report even after assertion errors.
sim_out="$(./obj_dir/uart_rx_sim +verilator+error+limit+1000)" || true
echo "$sim_out"

if grep -qx "Verification passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
